// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_pkg.sv
  - rv_fetch.sv
  - rv_regfile.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_result.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_clock.sv
      - tb_rv_core.sv

// ==== rv_core.sv ====
/*
 * Top of the five-stage RV32I pipeline. Connects fetch, decode, execute
 * and result to the instruction and data memory ports.
 */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_core import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_XLEN-1:0] instr_addr,
    input  logic [`RV_XLEN-1:0] instr_data,
    output mem_req_t            data_req,
    input  logic [`RV_XLEN-1:0] data_rdata
);

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;
    redirect_t redirect;
    logic      stall;

    rv_fetch fetch0 (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .redirect   (redirect),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .if_id      (if_id)
    );

    rv_decode decode0 (
        .clk      (clk),
        .rst      (rst),
        .if_id    (if_id),
        .wb       (wb),
        .redirect (redirect),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    rv_execute execute0 (
        .clk      (clk),
        .rst      (rst),
        .id_ex    (id_ex),
        .wb       (wb),
        .redirect (redirect),
        .ex_mem   (ex_mem)
    );

    // EX/MEM lives in execute, MEM/WB in result
    rv_result result0 (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .wb         (wb)
    );

endmodule

// ==== rv_decode.sv ====
/*
 * Decode stage. Decodes control, builds the immediate, reads the register
 * file, detects the load-use hazard and fills the ID/EX register.
 */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_decode import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  if_id_t    if_id,
    input  wb_t       wb,
    input  redirect_t redirect,
    output logic      stall,
    output id_ex_t    id_ex
);

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic [`RV_XLEN-1:0]       imm;
    ctrl_t                     ctrl;
    logic                      bubble;

    assign opcode = if_id.instr[6:0];
    assign rd     = if_id.instr[11:7];
    assign funct3 = if_id.instr[14:12];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];
    assign funct7 = if_id.instr[31:25];

    rv_regfile rf0 (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    // Unsupported encodings decode to a no-op
    always_comb begin
        ctrl = '0;
        case (opcode)
            `RV_OP_R: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b101:  ctrl.alu_op = ALU_SRL;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            `RV_OP_I: begin
                ctrl.reg_write   = (funct3 == 3'b000);
                ctrl.alu_src_imm = 1'b1;
            end
            `RV_OP_LOAD: begin
                ctrl.reg_write   = (funct3 == 3'b010);
                ctrl.mem_read    = (funct3 == 3'b010);
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            `RV_OP_STORE: begin
                ctrl.mem_write   = (funct3 == 3'b010);
                ctrl.alu_src_imm = 1'b1;
            end
            `RV_OP_BRANCH: begin
                ctrl.is_beq = (funct3 == 3'b000);
                ctrl.is_bne = (funct3 == 3'b001);
            end
            default: ctrl = '0;
        endcase
    end

    // I, S or B immediate, sign extended
    always_comb begin
        case (opcode)
            `RV_OP_STORE:  imm = {{20{funct7[6]}}, funct7, rd};
            `RV_OP_BRANCH: imm = {{20{funct7[6]}}, rd[0], funct7[5:0], rd[4:1], 1'b0};
            default:       imm = {{20{funct7[6]}}, funct7, rs2};
        endcase
    end

    // Load in execute whose result is needed here
    assign stall = if_id.valid && id_ex.ctrl.mem_read && (id_ex.rd != '0)
                   && ((id_ex.rd == rs1) || (id_ex.rd == rs2));

    assign bubble = rst || redirect.valid || stall || !if_id.valid;

    always_ff @(posedge clk) begin
        id_ex.pc  <= if_id.pc;
        id_ex.rs1 <= rs1;
        id_ex.rs2 <= rs2;
        id_ex.rd  <= rd;
        id_ex.a   <= rs1_data;
        id_ex.b   <= rs2_data;
        id_ex.imm <= imm;
        if (bubble) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= ctrl;
        end
    end

endmodule

// ==== rv_defines.svh ====
/*
 * Widths, reset values and opcodes for the RV32I pipeline.
 * Included by the package and by every RTL module.
 */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath sizes
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32

// Reset state
`define RV_PC_RST_VAL  32'h0000_0000
`define RV_SP_REG      2
`define RV_SP_RST_VAL  32'h0000_0ffc

// Major opcodes handled by the decoder
`define RV_OP_R        7'b0110011
`define RV_OP_I        7'b0010011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_BRANCH   7'b1100011

`endif

// ==== rv_execute.sv ====
/*
 * Execute stage. Forwards operands from EX/MEM and write-back, runs the ALU,
 * resolves beq and bne and fills the EX/MEM register.
 */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_execute import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  id_ex_t    id_ex,
    input  wb_t       wb,
    output redirect_t redirect,
    output ex_mem_t   ex_mem
);

    logic [`RV_XLEN-1:0] a_fwd;
    logic [`RV_XLEN-1:0] b_fwd;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                equal;
    ex_mem_t             ex_mem_d;

    // Newest producer first, x0 is never forwarded
    function automatic logic [`RV_XLEN-1:0] fwd_operand(
        input logic [`RV_REG_ADDR_W-1:0] rs,
        input logic [`RV_XLEN-1:0]       reg_val,
        input ex_mem_t                   mem_stage,
        input wb_t                       wb_stage
    );
        logic [`RV_XLEN-1:0] val;
        val = reg_val;
        if (rs != '0) begin
            if (mem_stage.reg_write && (mem_stage.rd == rs)) begin
                val = mem_stage.alu_result;
            end else if (wb_stage.reg_write && (wb_stage.rd == rs)) begin
                val = wb_stage.data;
            end
        end
        return val;
    endfunction

    assign a_fwd = fwd_operand(id_ex.rs1, id_ex.a, ex_mem, wb);
    assign b_fwd = fwd_operand(id_ex.rs2, id_ex.b, ex_mem, wb);
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : b_fwd;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = a_fwd + alu_b;
            ALU_SUB: alu_result = a_fwd - alu_b;
            ALU_AND: alu_result = a_fwd & alu_b;
            ALU_OR:  alu_result = a_fwd | alu_b;
            ALU_XOR: alu_result = a_fwd ^ alu_b;
            ALU_SLT: alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(a_fwd) < $signed(alu_b)};
            ALU_SLL: alu_result = a_fwd << alu_b[4:0];
            ALU_SRL: alu_result = a_fwd >> alu_b[4:0];
            default: alu_result = a_fwd + alu_b;
        endcase
    end

    // Branches are predicted not taken, so only a taken one redirects
    assign equal           = (a_fwd == b_fwd);
    assign redirect.valid  = (id_ex.ctrl.is_beq && equal) || (id_ex.ctrl.is_bne && !equal);
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
        ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_d.mem_to_reg = id_ex.ctrl.mem_to_reg;
        ex_mem_d.rd         = id_ex.rd;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = b_fwd;
    end

    always_ff @(posedge clk) begin
        ex_mem <= ex_mem_d;
        if (rst) begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
        end
    end

endmodule

// ==== rv_fetch.sv ====
/*
 * Fetch stage. Holds the PC, picks the next PC and fills the IF/ID register.
 * A redirect from execute wins over a stall from decode.
 */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_fetch import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  redirect_t           redirect,
    output logic [`RV_XLEN-1:0] instr_addr,
    input  logic [`RV_XLEN-1:0] instr_data,
    output if_id_t              if_id
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;

    always_comb begin
        if (redirect.valid) begin
            pc_next = redirect.target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + (`RV_XLEN)'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_PC_RST_VAL;
        end else begin
            pc <= pc_next;
        end
    end

    assign instr_addr = pc;

    // IF/ID register, the word fetched on a redirect is dropped
    always_ff @(posedge clk) begin
        if (!stall || redirect.valid) begin
            if_id.pc    <= pc;
            if_id.instr <= instr_data;
        end
        if (rst || redirect.valid) begin
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
        end
    end

endmodule

// ==== rv_pkg.sv ====
/*
 * Types shared by the pipeline stages: stage registers, control flags,
 * ALU operations and the data memory request. Imported by every stage.
 */
`include "rv_defines.svh"

package rv_pkg;

    // ALU_ADD must stay at zero so a cleared control word is a plain add
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        logic    is_beq;
        logic    is_bne;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       a;
        logic [`RV_XLEN-1:0]       b;
        logic [`RV_XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
        logic                      mem_to_reg;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       alu_result;
        logic [`RV_XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                      reg_write;
        logic                      mem_to_reg;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       alu_result;
        logic [`RV_XLEN-1:0]       load_data;
    } mem_wb_t;

    // Write-back bus, also the second forwarding source
    typedef struct packed {
        logic                      reg_write;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic                rd_en;
        logic                wr_en;
    } mem_req_t;

endpackage

// ==== rv_regfile.sv ====
/*
 * 32 x 32 register file with two combinational read ports.
 * x0 reads as zero, x2 comes out of reset as the stack pointer.
 */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_regfile import rv_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data,
    input  wb_t                       wb
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];
    logic                wr_en;

    // x0 is never written, so it keeps its reset value of zero
    assign wr_en = wb.reg_write && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            regs[`RV_SP_REG] <= `RV_SP_RST_VAL;
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through so decode sees a value written in the same cycle
    assign rs1_data = (wr_en && (wb.rd == rs1_addr)) ? wb.data : regs[rs1_addr];
    assign rs2_data = (wr_en && (wb.rd == rs2_addr)) ? wb.data : regs[rs2_addr];

endmodule

// ==== rv_result.sv ====
/*
 * Memory and write-back stages. Drives the data memory request from EX/MEM,
 * captures the load data in MEM/WB and selects the write-back value.
 */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_result import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  ex_mem_t             ex_mem,
    output mem_req_t            data_req,
    input  logic [`RV_XLEN-1:0] data_rdata,
    output wb_t                 wb
);

    mem_wb_t mem_wb;

    // Address always comes from the ALU, data memory answers in the same cycle
    assign data_req.addr  = ex_mem.alu_result;
    assign data_req.wdata = ex_mem.store_data;
    assign data_req.rd_en = ex_mem.mem_read;
    assign data_req.wr_en = ex_mem.mem_write;

    always_ff @(posedge clk) begin
        mem_wb.rd         <= ex_mem.rd;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.load_data  <= data_rdata;
        if (rst) begin
            mem_wb.reg_write  <= 1'b0;
            mem_wb.mem_to_reg <= 1'b0;
        end else begin
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
        end
    end

    assign wb.reg_write = mem_wb.reg_write;
    assign wb.rd        = mem_wb.rd;
    assign wb.data      = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// ==== tb.f ====
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

// ==== tb_clock.sv ====
/*
 * Clock and reset for the core testbench. 4 ns clock, reset held for
 * 16 cycles at start and again after each rising edge of reset_req.
 */
`timescale 1ns/1ns

module tb_clock (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release lands 1 ns after the edge, like all other stimulus
    always begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge reset_req);
    end

endmodule

// ==== tb_rv_core.sv ====
/*
 * Testbench for the RV32I pipeline. Runs a table of small programs from reset
 * and checks every data memory store against values from the RISC-V rules.
 */
`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_rv_core import rv_pkg::*; ();

    localparam int          NUM_TESTS  = 7;
    localparam int          MAX_WORDS  = 16;
    localparam int          MAX_STORES = 4;
    localparam int          RUN_LIMIT  = 4 * MAX_WORDS;
    localparam logic [31:0] END_ADDR   = 32'h0000_0ff8;

    logic                clk;
    logic                rst;
    logic                reset_req;
    logic [`RV_XLEN-1:0] instr_addr;
    logic [`RV_XLEN-1:0] instr_data;
    mem_req_t            data_req;
    logic [`RV_XLEN-1:0] data_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] prog_tab [NUM_TESTS][MAX_WORDS];
    int          prog_len [NUM_TESTS];
    logic [31:0] st_addr_tab [NUM_TESTS][MAX_STORES];
    logic [31:0] st_data_tab [NUM_TESTS][MAX_STORES];
    int          st_cnt [NUM_TESTS];
    int          ld_cnt [NUM_TESTS];
    string       test_name [NUM_TESTS];
    logic [31:0] lfsr_state;
    int          cur_test;
    int          st_idx;
    int          reads;
    int          errors;
    int          failed;
    logic        done;

    tb_clock clk0 (.reset_req(reset_req), .clk(clk), .rst(rst));

    rv_core dut0 (
        .clk        (clk),
        .rst        (rst),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_req   (data_req),
        .data_rdata (data_rdata)
    );

    // Both memories answer combinationally, word addressed modulo 256
    assign instr_data = imem[instr_addr[9:2]];
    assign data_rdata = data_req.rd_en ? dmem[data_req.addr[9:2]] : '0;

    always @(posedge clk) begin
        if (data_req.wr_en) begin
            dmem[data_req.addr[9:2]] <= data_req.wdata;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] x);
        return {{20{x[11]}}, x};
    endfunction

    function automatic logic [31:0] enc_r(input logic [3:0] f, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {1'b0, f[3], 5'b0, rs2, rs1, f[2:0], rd, `RV_OP_R};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, `RV_OP_I};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, `RV_OP_LOAD};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    // Op codes 0..7 are add sub and or xor slt sll srl, given as {funct7[5], funct3}
    function automatic logic [3:0] op_fields(input int code);
        case (code)
            0:       return 4'b0_000;
            1:       return 4'b1_000;
            2:       return 4'b0_111;
            3:       return 4'b0_110;
            4:       return 4'b0_100;
            5:       return 4'b0_010;
            6:       return 4'b0_001;
            default: return 4'b0_101;
        endcase
    endfunction

    // Code 8 is addi
    function automatic logic [31:0] model_op(input int code, input logic [31:0] a,
                                             input logic [31:0] b, input logic [31:0] imm);
        logic [3:0] f;
        f = op_fields(code);
        if (code == 8) begin
            return a + imm;
        end
        case (f[2:0])
            3'b000:  return f[3] ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input int t, input logic [31:0] w);
        prog_tab[t][prog_len[t]] = w;
        prog_len[t] = prog_len[t] + 1;
    endtask

    task automatic add_store(input int t, input logic [31:0] addr, input logic [31:0] data);
        st_addr_tab[t][st_cnt[t]] = addr;
        st_data_tab[t][st_cnt[t]] = data;
        st_cnt[t] = st_cnt[t] + 1;
    endtask

    // Random operand as (hi << sh) + lo, x7 holds the shift amount
    task automatic build_operand(input int t, input logic [4:0] rg, output logic [31:0] val);
        logic [31:0] hi;
        logic [31:0] sh;
        logic [31:0] lo;
        take_bits(12, hi);
        take_bits(5, sh);
        take_bits(12, lo);
        emit(t, enc_addi(rg, 5'd0, hi[11:0]));
        emit(t, enc_addi(5'd7, 5'd0, sh[11:0]));
        emit(t, enc_r(4'b0_001, rg, rg, 5'd7));
        emit(t, enc_addi(rg, rg, lo[11:0]));
        val = (sext12(hi[11:0]) << sh[4:0]) + sext12(lo[11:0]);
    endtask

    task automatic alu_test(input int t, input int first);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        int          code;
        build_operand(t, 5'd5, a);
        build_operand(t, 5'd6, b);
        take_bits(12, imm);
        for (int k = 0; k < 3; k++) begin
            code = first + k;
            if (code == 8) begin
                emit(t, enc_addi(5'd10, 5'd5, imm[11:0]));
            end else begin
                emit(t, enc_r(op_fields(code), 5'd10, 5'd5, 5'd6));
            end
            emit(t, enc_sw(5'd10, 5'd0, 12'h100 + 12'(4 * k)));
            add_store(t, 32'h100 + 4 * k, model_op(code, a, b, sext12(imm[11:0])));
        end
    endtask

    // End marker store at x2 - 4, then a branch to itself
    task automatic close_program(input int t);
        emit(t, enc_sw(5'd0, 5'd2, 12'hffc));
        emit(t, enc_branch(3'b000, 5'd0, 5'd0, 13'd0));
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] w;
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
            st_cnt[t]   = 0;
            ld_cnt[t]   = 0;
        end
        test_name[0] = "alu add sub and";
        alu_test(0, 0);
        test_name[1] = "alu or xor slt";
        alu_test(1, 3);
        test_name[2] = "alu sll srl addi";
        alu_test(2, 6);

        // Each result feeds the next two instructions
        test_name[3] = "forwarding chain";
        take_bits(12, a);
        take_bits(12, b);
        a = sext12(a[11:0]);
        b = a + sext12(b[11:0]);
        emit(3, enc_addi(5'd5, 5'd0, a[11:0]));
        emit(3, enc_addi(5'd6, 5'd5, 12'(b - a)));
        emit(3, enc_r(4'b0_000, 5'd7, 5'd6, 5'd5));
        emit(3, enc_r(4'b0_100, 5'd8, 5'd7, 5'd6));
        emit(3, enc_r(4'b1_000, 5'd9, 5'd8, 5'd7));
        emit(3, enc_sw(5'd9, 5'd0, 12'h200));
        emit(3, enc_sw(5'd8, 5'd0, 12'h204));
        emit(3, enc_sw(5'd7, 5'd0, 12'h208));
        emit(3, enc_sw(5'd6, 5'd0, 12'h20c));
        add_store(3, 32'h200, ((b + a) ^ b) - (b + a));
        add_store(3, 32'h204, (b + a) ^ b);
        add_store(3, 32'h208, b + a);
        add_store(3, 32'h20c, b);

        test_name[4] = "load use";
        take_bits(12, v);
        take_bits(12, w);
        emit(4, enc_addi(5'd5, 5'd0, v[11:0]));
        emit(4, enc_addi(5'd9, 5'd0, w[11:0]));
        emit(4, enc_sw(5'd5, 5'd0, 12'h300));
        emit(4, enc_lw(5'd6, 5'd0, 12'h300));
        emit(4, enc_r(4'b0_000, 5'd7, 5'd6, 5'd9));
        emit(4, enc_sw(5'd7, 5'd0, 12'h304));
        emit(4, enc_lw(5'd8, 5'd0, 12'h300));
        emit(4, enc_sw(5'd8, 5'd0, 12'h308));
        add_store(4, 32'h300, sext12(v[11:0]));
        add_store(4, 32'h304, sext12(v[11:0]) + sext12(w[11:0]));
        add_store(4, 32'h308, sext12(v[11:0]));
        // Each lw reads the data memory exactly once
        ld_cnt[4] = 2;

        // Stores to 0x400, 0x404 and 0x410 sit in the shadow of taken branches
        test_name[5] = "branches";
        emit(5, enc_addi(5'd5, 5'd0, 12'd7));
        emit(5, enc_addi(5'd6, 5'd0, 12'd7));
        emit(5, enc_branch(3'b000, 5'd5, 5'd6, 13'd12));
        emit(5, enc_sw(5'd5, 5'd0, 12'h400));
        emit(5, enc_sw(5'd6, 5'd0, 12'h404));
        emit(5, enc_sw(5'd5, 5'd0, 12'h408));
        emit(5, enc_addi(5'd6, 5'd6, 12'd1));
        emit(5, enc_branch(3'b001, 5'd5, 5'd5, 13'd8));
        emit(5, enc_sw(5'd6, 5'd0, 12'h40c));
        emit(5, enc_branch(3'b001, 5'd5, 5'd6, 13'd8));
        emit(5, enc_sw(5'd5, 5'd0, 12'h410));
        emit(5, enc_sw(5'd6, 5'd0, 12'h414));
        add_store(5, 32'h408, 32'd7);
        add_store(5, 32'h40c, 32'd8);
        add_store(5, 32'h414, 32'd8);

        test_name[6] = "register reset";
        emit(6, enc_sw(5'd2, 5'd0, 12'h500));
        emit(6, enc_addi(5'd0, 5'd0, 12'h123));
        emit(6, enc_sw(5'd0, 5'd0, 12'h504));
        add_store(6, 32'h500, `RV_SP_RST_VAL);
        add_store(6, 32'h504, 32'd0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            close_program(t);
        end
    endtask

    // Stores are checked in program order and reads counted at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            assert (data_req.wr_en !== 1'b1 && data_req.rd_en !== 1'b1) else begin
                $display("A data memory access was issued while reset was high at %0t",
                         $time);
                errors++;
            end
        end else begin
            if (data_req.rd_en === 1'b1) begin
                reads++;
            end
            if (data_req.wr_en === 1'b1) begin
                if (data_req.addr == END_ADDR) begin
                    done = 1'b1;
                end else if (st_idx >= st_cnt[cur_test]) begin
                    $display("Extra store to %h at %0t", data_req.addr, $time);
                    errors++;
                end else begin
                    assert (data_req.addr == st_addr_tab[cur_test][st_idx]
                            && data_req.wdata == st_data_tab[cur_test][st_idx]) else begin
                        $display("CHECK FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                                 $time, st_idx, data_req.wdata, data_req.addr,
                                 st_data_tab[cur_test][st_idx], st_addr_tab[cur_test][st_idx]);
                        errors++;
                    end
                    st_idx++;
                end
            end
        end
    end

    task automatic run_test(input int t);
        int cyc;
        @(posedge clk);
        #1;
        reset_req = 1'b1;
        wait (rst);
        reset_req = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_len[t]) ? prog_tab[t][i] : enc_addi(5'd0, 5'd0, 12'(i));
        end
        cur_test = t;
        st_idx   = 0;
        reads    = 0;
        done     = 1'b0;
        wait (!rst);
        cyc = 0;
        while (!done && cyc < RUN_LIMIT) begin
            @(posedge clk);
            cyc++;
        end
        if (!done) begin
            $display("%s: end marker store not seen within %0d cycles", test_name[t], RUN_LIMIT);
            errors++;
        end else if (st_idx < st_cnt[t]) begin
            $display("%s: %0d expected stores never happened", test_name[t], st_cnt[t] - st_idx);
            errors++;
        end
        assert (reads == ld_cnt[t]) else begin
            $display("CHECK FAILED at %0t: %0d data memory reads, expected %0d",
                     $time, reads, ld_cnt[t]);
            errors++;
        end
    endtask

    initial begin
        #(NUM_TESTS * (16 + 4 * MAX_WORDS) * 4 * 2);
        $display("Watchdog expired before the test loop finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        int err_before;
        reset_req  = 1'b0;
        lfsr_state = 32'h7e6f;
        errors     = 0;
        failed     = 0;
        done       = 1'b0;
        cur_test   = 0;
        st_idx     = 0;
        reads      = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_addi(5'd0, 5'd0, 12'(i));
            dmem[i] = 32'hc0de_0000 + 32'(i * 4);
        end
        build_table();
        wait (!rst);
        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before = errors;
            run_test(t);
            if (errors == err_before) begin
                $display("%s: PASS", test_name[t]);
            end else begin
                $display("%s: FAIL", test_name[t]);
                failed++;
            end
        end
        $display("%0d run, %0d passed, %0d failed, %0d errors",
                 NUM_TESTS, NUM_TESTS - failed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
